// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := psg_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/psg_bus_decode.sv ====
`default_nettype none

module psg_bus_decode #(
	parameter int NUM_VOICES = 3,
	parameter int WAVE_AW = 10
) (
	input  wire clk_i,
	input  wire arst_n_i,
	input  wire cyc_i,
	input  wire stb_i,
	input  wire we_i,
	input  wire psg_bus_pkg::wb_adr_t adr_i,
	input  wire psg_bus_pkg::wb_dat_t dat_i,
	output psg_bus_pkg::wb_dat_t dat_o,
	output logic ack_o,
	output logic tbl_we_o,
	output logic [WAVE_AW-1:0] tbl_idx_o,
	output psg_voice_pkg::sample_t tbl_wdata_o,
	input  wire psg_voice_pkg::sample_t tbl_rdata_i,
	output logic enable_o,
	output logic [NUM_VOICES*psg_voice_pkg::PHASE_W-1:0] freq_o,
	output logic [NUM_VOICES*psg_voice_pkg::VOL_W-1:0] volume_o
);
	import psg_bus_pkg::*;
	import psg_voice_pkg::*;

	logic req;
	logic tbl_sel;
	reg_idx_t reg_idx;
	logic wr_fire;
	logic rd_wait;
	logic ack_done;
	logic ctrl_en_q;
	freq_t freq_q [NUM_VOICES];
	volume_t vol_q [NUM_VOICES];
	wb_dat_t reg_rdata;

	// Word index of the frequency register of voice v
	function automatic reg_idx_t freq_idx(input int v);
		return REG_VOICE_BASE + reg_idx_t'(2 * v);
	endfunction

	// Word index of the volume register of voice v
	function automatic reg_idx_t vol_idx(input int v);
		return REG_VOICE_BASE + reg_idx_t'(2 * v + 1);
	endfunction

	// ============================================================
	// Address decode
	// ============================================================

	assign req = cyc_i & stb_i;
	assign tbl_sel = adr_i[TABLE_SEL_BIT];
	assign reg_idx = adr_i[TABLE_SEL_BIT-1:WORD_SEL_LSB];

	// A write takes effect once, in the first cycle the request is seen
	assign wr_fire = req & we_i & ~ack_o & ~ack_done;

	// The table CPU port follows the bus address directly
	assign tbl_we_o = wr_fire & tbl_sel;
	assign tbl_idx_o = adr_i[WORD_SEL_LSB +: WAVE_AW];
	// Only the upper 12 bits of a written word are kept
	assign tbl_wdata_o = dat_i[WB_DAT_W-1:SAMPLE_PAD_W];

	// ============================================================
	// Acknowledge sequencer
	// ============================================================

	// Table reads wait one extra cycle for the registered memory output
	// After the ack the sequencer stays quiet until stb drops
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ack_o <= 1'b0;
			rd_wait <= 1'b0;
			ack_done <= 1'b0;
		end
		else if (!req)
		begin
			ack_o <= 1'b0;
			rd_wait <= 1'b0;
			ack_done <= 1'b0;
		end
		else if (ack_o)
		begin
			ack_o <= 1'b0;
			ack_done <= 1'b1;
		end
		else if (!ack_done)
		begin
			if (we_i || !tbl_sel || rd_wait)
			begin
				ack_o <= 1'b1;
				rd_wait <= 1'b0;
			end
			else
				rd_wait <= 1'b1;
		end
	end

	// ============================================================
	// Control and voice registers
	// ============================================================

	// Writes to indices outside the map fall through every compare
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ctrl_en_q <= 1'b0;
			for (int v = 0; v < NUM_VOICES; v++)
			begin
				freq_q[v] <= '0;
				vol_q[v] <= '0;
			end
		end
		else if (wr_fire && !tbl_sel)
		begin
			if (reg_idx == REG_CTRL)
				ctrl_en_q <= dat_i[CTRL_EN_BIT];
			for (int v = 0; v < NUM_VOICES; v++)
			begin
				if (reg_idx == freq_idx(v))
					freq_q[v] <= dat_i;
				if (reg_idx == vol_idx(v))
					vol_q[v] <= dat_i[VOL_W-1:0];
			end
		end
	end

	// Register readback, zero for unmapped indices
	always_comb
	begin
		reg_rdata = '0;
		if (reg_idx == REG_CTRL)
			reg_rdata[CTRL_EN_BIT] = ctrl_en_q;
		for (int v = 0; v < NUM_VOICES; v++)
		begin
			if (reg_idx == freq_idx(v))
				reg_rdata = freq_q[v];
			if (reg_idx == vol_idx(v))
				reg_rdata = wb_dat_t'(vol_q[v]);
		end
	end

	// Table data returns with four zero bits below the sample
	assign dat_o = tbl_sel ? {tbl_rdata_i, {SAMPLE_PAD_W{1'b0}}} : reg_rdata;

	assign enable_o = ctrl_en_q;

	// Flatten the per-voice registers for the engine and mixer
	for (genvar v = 0; v < NUM_VOICES; v++)
	begin : g_flat
		assign freq_o[v*PHASE_W +: PHASE_W] = freq_q[v];
		assign volume_o[v*VOL_W +: VOL_W] = vol_q[v];
	end

	// The master holds its request until it sees the ack
	a_ack_in_cycle : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		ack_o |-> (cyc_i && stb_i)
	) else $error("ack_o high without an active cycle");

endmodule

`default_nettype wire

// ==== design/psg_bus_pkg.sv ====
`default_nettype none

package psg_bus_pkg;

	// ============================================================
	// Wishbone port widths
	// ============================================================

	localparam int WB_ADR_W = 16;
	localparam int WB_DAT_W = 16;

	// Byte address as the CPU drives it
	typedef logic [WB_ADR_W-1:0] wb_adr_t;

	// Every access moves a full word, there are no byte lanes
	typedef logic [WB_DAT_W-1:0] wb_dat_t;

	// ============================================================
	// Address split
	// ============================================================

	// The top address bit steers an access to the wave table
	localparam int TABLE_SEL_BIT = 15;

	// Bit 0 is the byte bit and never selects anything
	localparam int WORD_SEL_LSB = 1;

	// Word index into the register space, the bits below the table select
	localparam int REG_IDX_W = TABLE_SEL_BIT - WORD_SEL_LSB;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Register map in word indices
	localparam reg_idx_t REG_CTRL = reg_idx_t'(0);
	localparam int CTRL_EN_BIT = 0;

	// Voice v has its frequency at REG_VOICE_BASE+2v and its volume one word above
	localparam reg_idx_t REG_VOICE_BASE = reg_idx_t'(1);

	// A table sample sits in the upper bits of a bus word with zeros below it
	localparam int SAMPLE_PAD_W = 4;

endpackage

`default_nettype wire

// ==== design/psg_mixer.sv ====
`default_nettype none

module psg_mixer #(
	parameter int NUM_VOICES = 3,
	localparam int VOICE_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1,
	localparam int MIX_W = psg_voice_pkg::SAMPLE_W + $clog2(NUM_VOICES)
) (
	input  wire clk_i,
	input  wire arst_n_i,
	input  wire psg_voice_pkg::sample_t sample_i,
	input  wire sample_valid_i,
	input  wire [VOICE_W-1:0] voice_i,
	input  wire frame_end_i,
	input  wire [NUM_VOICES*psg_voice_pkg::VOL_W-1:0] volume_i,
	output logic [MIX_W-1:0] mix_o,
	output logic mix_valid_o
);
	import psg_voice_pkg::*;

	localparam int PROD_W = SAMPLE_W + VOL_W;

	volume_t vol;
	logic [PROD_W-1:0] product;
	sample_t scaled;
	logic [MIX_W-1:0] acc;
	logic [MIX_W-1:0] sum_next;

	// ============================================================
	// Volume scaling
	// ============================================================

	// Pick the volume of the voice whose sample is arriving
	assign vol = volume_i[voice_i*VOL_W +: VOL_W];

	// Full-width product, then drop four bits so that volume 15
	// gives 15/16 of the sample
	assign product = sample_i * vol;
	assign scaled = product[PROD_W-1:VOL_W];

	// ============================================================
	// Frame accumulation
	// ============================================================

	// Voice 0 opens a new frame and discards the previous sum
	// The extra log2 bits of MIX_W keep the total from overflowing
	assign sum_next = ((voice_i == '0) ? '0 : acc) + MIX_W'(scaled);

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			acc <= '0;
			mix_o <= '0;
			mix_valid_o <= 1'b0;
		end
		else
		begin
			mix_valid_o <= frame_end_i;
			if (sample_valid_i)
				acc <= sum_next;
			// mix_o only changes at the end of a frame
			if (frame_end_i)
				mix_o <= sum_next;
		end
	end

	// Frames are at least a sample period apart
	a_valid_pulse : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		mix_valid_o |=> !mix_valid_o
	) else $error("mix_valid_o high on two adjacent cycles");

endmodule

`default_nettype wire

// ==== design/psg_top.sv ====
`default_nettype none

module psg_top #(
	parameter int NUM_VOICES = 3,
	parameter int WAVE_AW = 10,
	// Must exceed NUM_VOICES+3 so each frame drains before the next tick
	parameter int SAMPLE_DIV = 32,
	localparam int VOICE_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1,
	localparam int MIX_W = psg_voice_pkg::SAMPLE_W + $clog2(NUM_VOICES)
) (
	input  wire clk_i,
	input  wire arst_n_i,

	// Wishbone classic slave
	input  wire cyc_i,
	input  wire stb_i,
	input  wire we_i,
	input  wire psg_bus_pkg::wb_adr_t adr_i,
	input  wire psg_bus_pkg::wb_dat_t dat_i,
	output psg_bus_pkg::wb_dat_t dat_o,
	output logic ack_o,

	// Mixed sample output, to be taken in the valid cycle
	output logic [MIX_W-1:0] mix_o,
	output logic mix_valid_o
);
	import psg_voice_pkg::*;

	// Bus decode to wave table CPU port
	logic tbl_we;
	logic [WAVE_AW-1:0] tbl_idx;
	sample_t tbl_wdata;
	sample_t tbl_rdata;

	// Voice engine to wave table voice port
	logic voice_rd;
	logic [WAVE_AW-1:0] voice_idx;
	sample_t voice_sample;

	// Voice settings from the register block
	logic enable;
	logic [NUM_VOICES*PHASE_W-1:0] freq;
	logic [NUM_VOICES*VOL_W-1:0] volume;

	// Sample tags from the engine to the mixer
	logic sample_valid;
	logic [VOICE_W-1:0] voice_num;
	logic frame_end;

	// ============================================================
	// Bus decode and registers
	// ============================================================

	psg_bus_decode #(
		.NUM_VOICES(NUM_VOICES),
		.WAVE_AW(WAVE_AW)
	) u_decode (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.dat_o(dat_o),
		.ack_o(ack_o),
		.tbl_we_o(tbl_we),
		.tbl_idx_o(tbl_idx),
		.tbl_wdata_o(tbl_wdata),
		.tbl_rdata_i(tbl_rdata),
		.enable_o(enable),
		.freq_o(freq),
		.volume_o(volume)
	);

	// ============================================================
	// Wave table
	// ============================================================

	wave_tbl_mem #(
		.WAVE_AW(WAVE_AW)
	) u_table (
		.clk_i(clk_i),
		.cpu_we_i(tbl_we),
		.cpu_idx_i(tbl_idx),
		.cpu_wdata_i(tbl_wdata),
		.cpu_rdata_o(tbl_rdata),
		.voice_rd_i(voice_rd),
		.voice_idx_i(voice_idx),
		.voice_rdata_o(voice_sample)
	);

	// ============================================================
	// Voice engine and mixer
	// ============================================================

	psg_voice_engine #(
		.NUM_VOICES(NUM_VOICES),
		.WAVE_AW(WAVE_AW),
		.SAMPLE_DIV(SAMPLE_DIV)
	) u_engine (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.enable_i(enable),
		.freq_i(freq),
		.tbl_rd_o(voice_rd),
		.tbl_idx_o(voice_idx),
		.sample_valid_o(sample_valid),
		.voice_o(voice_num),
		.frame_end_o(frame_end)
	);

	psg_mixer #(
		.NUM_VOICES(NUM_VOICES)
	) u_mixer (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.sample_i(voice_sample),
		.sample_valid_i(sample_valid),
		.voice_i(voice_num),
		.frame_end_i(frame_end),
		.volume_i(volume),
		.mix_o(mix_o),
		.mix_valid_o(mix_valid_o)
	);

endmodule

`default_nettype wire

// ==== design/psg_voice_engine.sv ====
`default_nettype none

module psg_voice_engine #(
	parameter int NUM_VOICES = 3,
	parameter int WAVE_AW = 10,
	parameter int SAMPLE_DIV = 32,
	localparam int VOICE_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1
) (
	input  wire clk_i,
	input  wire arst_n_i,
	input  wire enable_i,
	input  wire [NUM_VOICES*psg_voice_pkg::PHASE_W-1:0] freq_i,
	output logic tbl_rd_o,
	output logic [WAVE_AW-1:0] tbl_idx_o,
	output logic sample_valid_o,
	output logic [VOICE_W-1:0] voice_o,
	output logic frame_end_o
);
	import psg_voice_pkg::*;

	localparam int DIV_W = $clog2(SAMPLE_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);
	localparam logic [VOICE_W-1:0] LAST_VOICE = VOICE_W'(NUM_VOICES - 1);

	logic [DIV_W-1:0] div_cnt;
	logic tick;
	engine_state_e state;
	logic [VOICE_W-1:0] cur;
	phase_t phase_q [NUM_VOICES];
	phase_t cur_phase;
	freq_t cur_freq;

	// ============================================================
	// Sample period timer
	// ============================================================

	// Held at zero while disabled, so the first tick comes a full
	// period after enable rises
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			div_cnt <= '0;
		else if (!enable_i || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign tick = enable_i && (div_cnt == DIV_LAST);

	// ============================================================
	// Voice sequencer and phase accumulators
	// ============================================================

	assign cur_phase = phase_q[cur];
	assign cur_freq = freq_i[cur*PHASE_W +: PHASE_W];

	// The table index is the top of the phase before this frame's step
	assign tbl_rd_o = (state == FETCH);
	assign tbl_idx_o = cur_phase[PHASE_W-1 -: WAVE_AW];

	// One voice per clock in FETCH, then one cycle for the last read
	// Disabling drops everything back to phase zero
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state <= IDLE;
			cur <= '0;
			for (int v = 0; v < NUM_VOICES; v++)
				phase_q[v] <= '0;
		end
		else if (!enable_i)
		begin
			state <= IDLE;
			cur <= '0;
			for (int v = 0; v < NUM_VOICES; v++)
				phase_q[v] <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					state <= STEP;
				STEP:
					if (tick)
						state <= FETCH;
				FETCH:
				begin
					// Phase wraps modulo 2^16 by width
					phase_q[cur] <= cur_phase + cur_freq;
					if (cur == LAST_VOICE)
					begin
						cur <= '0;
						state <= FLUSH;
					end
					else
						cur <= cur + 1'b1;
				end
				FLUSH:
					state <= STEP;
				default:
					state <= IDLE;
			endcase
		end
	end

	// ============================================================
	// Sample tags
	// ============================================================

	// Delayed one cycle so they line up with the registered table data
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			sample_valid_o <= 1'b0;
			voice_o <= '0;
			frame_end_o <= 1'b0;
		end
		else if (!enable_i)
		begin
			sample_valid_o <= 1'b0;
			voice_o <= '0;
			frame_end_o <= 1'b0;
		end
		else
		begin
			sample_valid_o <= tbl_rd_o;
			voice_o <= cur;
			frame_end_o <= tbl_rd_o && (cur == LAST_VOICE);
		end
	end

	// The previous frame has drained by the time the next tick fires
	a_one_frame : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		tick |-> (state == STEP)
	) else $error("tick fired while a frame was still in progress");

endmodule

`default_nettype wire

// ==== design/psg_voice_pkg.sv ====
`default_nettype none

package psg_voice_pkg;

	// ============================================================
	// Voice datapath widths
	// ============================================================

	localparam int PHASE_W = 16;
	localparam int SAMPLE_W = 12;
	localparam int VOL_W = 4;

	// Phase accumulator, wraps modulo 2^16
	typedef logic [PHASE_W-1:0] phase_t;

	// Phase increment added once per sample period
	typedef logic [PHASE_W-1:0] freq_t;

	// Unsigned wave table sample
	typedef logic [SAMPLE_W-1:0] sample_t;

	// Volume, 0 is silent and 15 is 15/16 of full scale
	typedef logic [VOL_W-1:0] volume_t;

	// ============================================================
	// Voice engine sequencer
	// ============================================================

	// IDLE while disabled, STEP while waiting for the next tick,
	// FETCH while walking the voices, FLUSH while the last read is in flight
	typedef enum logic [1:0] {
		IDLE,
		STEP,
		FETCH,
		FLUSH
	} engine_state_e;

endpackage

`default_nettype wire

// ==== design/wave_tbl_mem.sv ====
`default_nettype none

module wave_tbl_mem #(
	parameter int WAVE_AW = 10
) (
	input  wire clk_i,

	// CPU side, read and write
	input  wire cpu_we_i,
	input  wire [WAVE_AW-1:0] cpu_idx_i,
	input  wire psg_voice_pkg::sample_t cpu_wdata_i,
	output psg_voice_pkg::sample_t cpu_rdata_o,

	// Voice engine side, read only
	input  wire voice_rd_i,
	input  wire [WAVE_AW-1:0] voice_idx_i,
	output psg_voice_pkg::sample_t voice_rdata_o
);
	import psg_voice_pkg::*;

	localparam int DEPTH = 2 ** WAVE_AW;

	// ============================================================
	// Sample storage
	// ============================================================

	// Contents are undefined until the CPU loads them
	sample_t mem [DEPTH];

	// ============================================================
	// CPU port
	// ============================================================

	// Writes land on the clock edge
	// The read register samples the table every cycle, so the data
	// for a held index is ready one cycle after the index appears
	// A read during a write to the same word returns the old sample
	always_ff @(posedge clk_i)
	begin
		if (cpu_we_i)
			mem[cpu_idx_i] <= cpu_wdata_i;
		cpu_rdata_o <= mem[cpu_idx_i];
	end

	// ============================================================
	// Voice port
	// ============================================================

	// The output register only moves on a read strobe, so the
	// last fetched sample stays put between frames
	always_ff @(posedge clk_i)
	begin
		if (voice_rd_i)
			voice_rdata_o <= mem[voice_idx_i];
	end

	// Both ports read independently, so CPU traffic never holds up
	// the voice engine

endmodule

`default_nettype wire

// ==== testbench/psg_tb.sv ====
`default_nettype none

module psg_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// ============================================================
	// Configuration
	// ============================================================

	localparam int NUM_VOICES = 3;
	localparam int WAVE_AW = 10;
	localparam int SAMPLE_DIV = 32;
	localparam int MIX_W = 14;
	localparam int TBL_DEPTH = 1 << WAVE_AW;
	localparam int NUM_REGS = 1 + 2 * NUM_VOICES;
	localparam int CLK_PERIOD = 10;
	localparam int SEED = 4;
	localparam int ACK_LIMIT = 8;

	// Iteration counts, which also size the watchdog
	localparam int REG_ITERS = 30;
	localparam int UNMAP_ITERS = 12;
	localparam int TBL_OVERWRITES = 40;
	localparam int TBL_READS = 60;
	localparam int RUN_FRAMES = 40;
	localparam int RESTART_FRAMES = 10;
	localparam int MAX_GAP = 20;

	localparam int NUM_ACCESSES = 3 * NUM_REGS + 2 * REG_ITERS + 2 * UNMAP_ITERS
		+ TBL_DEPTH + 2 * TBL_OVERWRITES + TBL_READS + (NUM_REGS + 1) + RUN_FRAMES + 2;
	localparam int IDLE_CYCLES = 3 + 20 + 4 + 4 * SAMPLE_DIV + RUN_FRAMES * MAX_GAP + 1000;
	localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 20
		+ (RUN_FRAMES + RESTART_FRAMES) * SAMPLE_DIV * 2 + IDLE_CYCLES;

	logic clk;
	logic arst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [15:0] adr;
	logic [15:0] dat_w;
	wire [15:0] dat_r;
	wire ack;
	wire [MIX_W-1:0] mix;
	wire mix_valid;

	// Reference model of the register block and the wave table
	logic [11:0] model_tbl [TBL_DEPTH];
	logic [15:0] model_freq [NUM_VOICES];
	logic [3:0] model_vol [NUM_VOICES];
	logic model_en;

	int check_count;
	int err_count;
	int tests_run;
	int tests_failed;
	int test_err_base;

	psg_top UUT (
		.clk_i(clk),
		.arst_n_i(arst_n),
		.cyc_i(cyc),
		.stb_i(stb),
		.we_i(we),
		.adr_i(adr),
		.dat_i(dat_w),
		.dat_o(dat_r),
		.ack_o(ack),
		.mix_o(mix),
		.mix_valid_o(mix_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// ============================================================
	// Address map and model
	// ============================================================

	// Byte address of register word idx
	function automatic logic [15:0] reg_addr(input int idx);
		return 16'(idx << 1);
	endfunction

	// Table words sit above the top address bit
	function automatic logic [15:0] tbl_addr(input int idx);
		return 16'h8000 | 16'(idx << 1);
	endfunction

	// Odd indices past control hold a frequency, even ones a volume
	function automatic logic [15:0] expected_reg(input int idx);
		int v;
		v = (idx - 1) / 2;
		if (idx == 0)
			return {15'h0, model_en};
		else if (idx > 2 * NUM_VOICES)
			return 16'h0;
		else if ((idx - 1) % 2 == 0)
			return model_freq[v];
		else
			return {12'h0, model_vol[v]};
	endfunction

	task automatic update_model_reg(input int idx, input logic [15:0] data);
		int v;
		v = (idx - 1) / 2;
		if (idx == 0)
			model_en = data[0];
		else if (idx <= 2 * NUM_VOICES && (idx - 1) % 2 == 0)
			model_freq[v] = data;
		else if (idx <= 2 * NUM_VOICES)
			model_vol[v] = data[3:0];
	endtask

	// Frame k reads every voice at phase k*freq, scaled by volume/16
	function automatic int unsigned expected_mix(input int k);
		int unsigned sum;
		int unsigned prod;
		logic [15:0] phase;
		sum = 0;
		for (int v = 0; v < NUM_VOICES; v++)
		begin
			phase = 16'(k * model_freq[v]);
			prod = model_tbl[phase[15 -: WAVE_AW]] * model_vol[v];
			sum += prod >> 4;
		end
		return sum;
	endfunction

	// ============================================================
	// Wishbone master and checks
	// ============================================================

	// Request goes out 1 ns after an edge and is held until ack is seen
	task automatic wb_access(input logic write, input logic [15:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata);
		bit seen;
		seen = 1'b0;
		rdata = '0;
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		for (int i = 0; i < ACK_LIMIT && !seen; i++)
		begin
			@(posedge clk);
			#1;
			if (ack)
			begin
				seen = 1'b1;
				rdata = dat_r;
			end
		end
		assert (seen)
		else
		begin
			$display("Bus access to 0x%04h got no ack within %0d cycles", addr, ACK_LIMIT);
			err_count++;
		end
		// The slave samples the held request on the ack edge, release after it
		@(posedge clk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wb_write(input logic [15:0] addr, input logic [15:0] data);
		logic [15:0] unused;
		wb_access(1'b1, addr, data, unused);
	endtask

	task automatic wb_read(input logic [15:0] addr, output logic [15:0] data);
		wb_access(1'b0, addr, 16'h0, data);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		check_count++;
		assert (exp == got)
		else
		begin
			$display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, got);
			err_count++;
		end
	endtask

	task automatic read_all_regs(input string name);
		logic [15:0] rdata;
		for (int r = 0; r < NUM_REGS; r++)
		begin
			wb_read(reg_addr(r), rdata);
			check_value(name, 32'(expected_reg(r)), 32'(rdata));
		end
	endtask

	// Waits for each frame in turn and compares it with model frame k
	task automatic collect_frames(input string name, input int count);
		bit seen;
		bit lost;
		lost = 1'b0;
		for (int k = 0; k < count && !lost; k++)
		begin
			seen = 1'b0;
			for (int i = 0; i < 2 * SAMPLE_DIV && !seen; i++)
			begin
				@(posedge clk);
				#1;
				seen = mix_valid;
			end
			assert (seen)
			else
			begin
				$display("Test %s: frame %0d never arrived, mix_valid_o stayed low", name, k);
				err_count++;
				lost = 1'b1;
			end
			if (seen)
				check_value(name, expected_mix(k), 32'(mix));
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_count == test_err_base)
			$display("Test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("Test %s: %0d errors", name, err_count - test_err_base);
		end
		test_err_base = err_count;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial
	begin
		logic [15:0] rdata;
		logic [15:0] data;
		int idx;

		void'($urandom(SEED));
		arst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		model_en = 1'b0;
		check_count = 0;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err_base = 0;
		for (int v = 0; v < NUM_VOICES; v++)
		begin
			model_freq[v] = '0;
			model_vol[v] = '0;
		end

		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Quiet bus and output after reset, all registers cleared
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			#1;
			check_value("reset_idle", 0, 32'(ack));
			check_value("reset_idle", 0, 32'(mix_valid));
		end
		for (int r = 0; r < NUM_REGS; r++)
		begin
			wb_read(reg_addr(r), rdata);
			check_value("reset_idle", 0, 32'(rdata));
		end
		finish_test("reset_idle");

		// Register write and readback, masked by the model
		for (int i = 0; i < REG_ITERS; i++)
		begin
			idx = $urandom_range(NUM_REGS - 1, 0);
			data = 16'($urandom);
			wb_write(reg_addr(idx), data);
			update_model_reg(idx, data);
			wb_read(reg_addr(idx), rdata);
			check_value("reg_rw", 32'(expected_reg(idx)), 32'(rdata));
		end
		read_all_regs("reg_rw");
		finish_test("reg_rw");

		// Unmapped indices read as zero and disturb nothing
		for (int i = 0; i < UNMAP_ITERS; i++)
		begin
			idx = NUM_REGS + $urandom_range((1 << 14) - 1 - NUM_REGS, 0);
			wb_write(reg_addr(idx), 16'($urandom));
			wb_read(reg_addr(idx), rdata);
			check_value("unmapped", 0, 32'(rdata));
		end
		read_all_regs("unmapped");
		finish_test("unmapped");

		// Fill the whole table, then overwrite and read at random
		for (int t = 0; t < TBL_DEPTH; t++)
		begin
			data = 16'($urandom);
			wb_write(tbl_addr(t), data);
			model_tbl[t] = data[15:4];
		end
		for (int i = 0; i < TBL_OVERWRITES; i++)
		begin
			idx = $urandom_range(TBL_DEPTH - 1, 0);
			data = 16'($urandom);
			wb_write(tbl_addr(idx), data);
			model_tbl[idx] = data[15:4];
			wb_read(tbl_addr(idx), rdata);
			check_value("table_rw", 32'({model_tbl[idx], 4'h0}), 32'(rdata));
		end
		for (int i = 0; i < TBL_READS; i++)
		begin
			idx = $urandom_range(TBL_DEPTH - 1, 0);
			wb_read(tbl_addr(idx), rdata);
			check_value("table_rw", 32'({model_tbl[idx], 4'h0}), 32'(rdata));
		end
		finish_test("table_rw");

		// Disabled while the voices are set up, so phases restart at zero
		wb_write(reg_addr(0), 16'h0000);
		update_model_reg(0, 16'h0000);
		for (int r = 1; r < NUM_REGS; r++)
		begin
			data = 16'($urandom);
			wb_write(reg_addr(r), data);
			update_model_reg(r, data);
		end
		wb_write(reg_addr(0), 16'h0001);
		update_model_reg(0, 16'h0001);
		fork
			collect_frames("frames", RUN_FRAMES);
			begin
				int ridx;
				logic [15:0] rd;
				// CPU reads on the other port while the engine runs
				for (int i = 0; i < RUN_FRAMES; i++)
				begin
					repeat ($urandom_range(MAX_GAP, 0)) @(posedge clk);
					ridx = $urandom_range(TBL_DEPTH - 1, 0);
					wb_read(tbl_addr(ridx), rd);
					check_value("frames", 32'({model_tbl[ridx], 4'h0}), 32'(rd));
				end
			end
		join
		finish_test("frames");

		// No output while disabled, then frame 0 again after enable
		wb_write(reg_addr(0), 16'h0000);
		update_model_reg(0, 16'h0000);
		// A frame that ended right at the disable may still pulse once
		repeat (4) @(posedge clk);
		for (int i = 0; i < 4 * SAMPLE_DIV; i++)
		begin
			@(posedge clk);
			#1;
			check_value("restart", 0, 32'(mix_valid));
		end
		wb_write(reg_addr(0), 16'h0001);
		update_model_reg(0, 16'h0001);
		collect_frames("restart", RESTART_FRAMES);
		finish_test("restart");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0 && tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Ends a run that hangs on a lost ack or frame
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/psg_bus_pkg.sv
design/psg_voice_pkg.sv
design/psg_bus_decode.sv
design/wave_tbl_mem.sv
design/psg_voice_engine.sv
design/psg_mixer.sv
design/psg_top.sv
testbench/psg_tb.sv
